// ==== Makefile ====
# Verilator build for the cartridge controller testbench

TOP := tb_cart_main

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	out="$$(./obj_dir/sim_$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

// ==== hw/cart_main.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_main (
  input  wire logic                  CLK2,
  input  wire logic                  rst,
  // console cpu bus
  input  wire cart_pkg::snes_addr_t  snes_addr_in,
  input  wire logic                  snes_read_in,
  input  wire logic                  snes_write_in,
  input  wire logic                  snes_romsel_in,
  input  wire logic                  snes_cpu_clk_in,
  input  wire cart_pkg::byte_t       snes_data_in,
  output cart_pkg::byte_t            snes_data_out,
  output logic                       snes_data_drive,
  output logic                       snes_databus_oe,
  output logic                       snes_databus_dir,
  // map setup from the mcu
  input  wire cart_pkg::psram_addr_t rom_mask,
  input  wire cart_pkg::psram_addr_t saveram_mask,
  // mcu access
  input  wire logic                  mcu_rrq,
  input  wire logic                  mcu_wrq,
  input  wire cart_pkg::psram_addr_t mcu_addr,
  input  wire cart_pkg::byte_t       mcu_dout,
  output cart_pkg::byte_t            mcu_din,
  output logic                       mcu_rdy,
  // psram
  input  wire logic [15:0]           rom_data_in,
  output logic [22:0]                rom_addr,
  output logic [15:0]                rom_data_out,
  output logic                       rom_data_drive,
  output logic                       rom_we,
  output logic                       rom_bhe,
  output logic                       rom_ble
);
  import cart_pkg::*;

  snes_addr_t snes_addr;
  byte_t      snes_wdata;
  logic       snes_read;
  logic       snes_write;
  logic       snes_romsel;
  logic       rd_start;
  logic       wr_end;
  logic       free_slot;
  logic       snes_dead;
  logic       rom_hit;

  psram_port_if snes_port ();
  psram_port_if mcu_port ();

  //////////////////////////////////////////////////
  // blocks
  //////////////////////////////////////////////////

  snes_bus_sampler u_sampler (
    .CLK2            (CLK2),
    .rst             (rst),
    .snes_addr_in    (snes_addr_in),
    .snes_read_in    (snes_read_in),
    .snes_write_in   (snes_write_in),
    .snes_romsel_in  (snes_romsel_in),
    .snes_cpu_clk_in (snes_cpu_clk_in),
    .snes_data_in    (snes_data_in),
    .rom_hit         (rom_hit),
    .snes_addr       (snes_addr),
    .snes_wdata      (snes_wdata),
    .snes_read       (snes_read),
    .snes_write      (snes_write),
    .snes_romsel     (snes_romsel),
    .rd_start        (rd_start),
    .wr_end          (wr_end),
    .free_slot       (free_slot),
    .snes_dead       (snes_dead)
  );

  snes_rom_map u_map (
    .CLK2         (CLK2),
    .rst          (rst),
    .snes_addr    (snes_addr),
    .snes_romsel  (snes_romsel),
    .snes_write   (snes_write),
    .snes_wdata   (snes_wdata),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .rom_hit      (rom_hit),
    .snes_port    (snes_port)
  );

  mcu_access u_mcu (
    .CLK2      (CLK2),
    .rst       (rst),
    .mcu_rrq   (mcu_rrq),
    .mcu_wrq   (mcu_wrq),
    .mcu_addr  (mcu_addr),
    .mcu_dout  (mcu_dout),
    .free_slot (free_slot),
    .snes_dead (snes_dead),
    .mcu_din   (mcu_din),
    .mcu_rdy   (mcu_rdy),
    .mcu_port  (mcu_port)
  );

  psram_arbiter u_arb (
    .rom_data_in    (rom_data_in),
    .snes_port      (snes_port),
    .mcu_port       (mcu_port),
    .rom_addr       (rom_addr),
    .rom_data_out   (rom_data_out),
    .rom_data_drive (rom_data_drive),
    .rom_we         (rom_we),
    .rom_bhe        (rom_bhe),
    .rom_ble        (rom_ble)
  );

  //////////////////////////////////////////////////
  // console data bus
  //////////////////////////////////////////////////

  // level shifter enable, active low
  // write end releases it one cycle ahead of the filtered level
  // direction 1 drives toward the console, confirmed read start also turns it
  always_ff @(posedge CLK2) begin
    if (rst) begin
      snes_databus_oe  <= 1'b1;
      snes_databus_dir <= 1'b0;
    end else begin
      snes_databus_oe  <= ~(rom_hit & (~snes_read | (~snes_write & ~wr_end)));
      snes_databus_dir <= ~snes_read | rd_start;
    end
  end

  assign snes_data_drive = snes_databus_dir;
  // straight from the psram lanes
  assign snes_data_out = snes_port.rdata;

endmodule

`default_nettype wire

// ==== hw/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

  //////////////////////////////////////////////////
  // data and address types
  //////////////////////////////////////////////////

  // one data byte on either bus
  typedef logic [7:0] byte_t;
  // console address, bank in 23:16
  typedef logic [23:0] snes_addr_t;
  // psram byte address, bit 0 picks the lane
  typedef logic [23:0] psram_addr_t;

  //////////////////////////////////////////////////
  // timing
  //////////////////////////////////////////////////

  // strobe shift registers
  localparam int SAMPLE_DEPTH = 8;
  // address and write data pipelines
  localparam int ADDR_DELAY = 7;
  localparam int DATA_DELAY = 4;

  // mcu cycle delay counter reload
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd7;

  // one-hot states of the mcu access fsm
  localparam logic [4:0] ST_IDLE        = 5'b00001;
  localparam logic [4:0] ST_MCU_RD_ADDR = 5'b00010;
  localparam logic [4:0] ST_MCU_RD_END  = 5'b00100;
  localparam logic [4:0] ST_MCU_WR_ADDR = 5'b01000;
  localparam logic [4:0] ST_MCU_WR_END  = 5'b10000;

  // liveness, about 1 ms at 96 MHz
  localparam int DEAD_CNT_W = 17;
  localparam logic [DEAD_CNT_W-1:0] DEAD_TIMEOUT = 17'd96000;

  //////////////////////////////////////////////////
  // address map
  //////////////////////////////////////////////////

  localparam psram_addr_t SAVERAM_BASE = 24'hE0_0000;
  localparam byte_t SAVERAM_BANK_LO = 8'h70;
  localparam byte_t SAVERAM_BANK_HI = 8'h7D;

endpackage

`default_nettype wire

// ==== hw/mcu_access.sv ====
`timescale 1ns/100ps
`default_nettype none

module mcu_access (
  input  wire logic                  CLK2,
  input  wire logic                  rst,
  input  wire logic                  mcu_rrq,
  input  wire logic                  mcu_wrq,
  input  wire cart_pkg::psram_addr_t mcu_addr,
  input  wire cart_pkg::byte_t       mcu_dout,
  input  wire logic                  free_slot,
  input  wire logic                  snes_dead,
  output cart_pkg::byte_t            mcu_din,
  output logic                       mcu_rdy,
  psram_port_if.requester            mcu_port
);
  import cart_pkg::*;

  logic [4:0]  state;
  logic [3:0]  delay;
  logic        rd_pend;
  logic        wr_pend;
  logic        dead_q;
  logic        revived;
  logic        at_end;
  psram_addr_t addr_r;
  byte_t       wdata_r;

  // console just came back, abort and retry later
  assign revived = dead_q & ~snes_dead;
  assign at_end  = (state == ST_MCU_RD_END) || (state == ST_MCU_WR_END);

  //////////////////////////////////////////////////
  // request latch and ready flag
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
      dead_q  <= 1'b1;
    end else begin
      dead_q <= snes_dead;
      if (mcu_rrq) begin
        rd_pend <= 1'b1;
        mcu_rdy <= 1'b0;
      end else if (mcu_wrq) begin
        wr_pend <= 1'b1;
        mcu_rdy <= 1'b0;
      end else if (at_end) begin
        rd_pend <= 1'b0;
        wr_pend <= 1'b0;
        mcu_rdy <= 1'b1;
      end
    end
  end

  // held for the whole access
  always_ff @(posedge CLK2) begin
    if (mcu_rrq || mcu_wrq) begin
      addr_r  <= mcu_addr;
      wdata_r <= mcu_dout;
    end
  end

  //////////////////////////////////////////////////
  // access fsm
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst || revived) begin
      state <= ST_IDLE;
      delay <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          // wait for a slot the console leaves free
          if (free_slot || snes_dead) begin
            if (rd_pend) begin
              state <= ST_MCU_RD_ADDR;
              delay <= ROM_CYCLE_LEN;
            end else if (wr_pend) begin
              state <= ST_MCU_WR_ADDR;
              delay <= ROM_CYCLE_LEN;
            end
          end
        end
        ST_MCU_RD_ADDR, ST_MCU_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= (state == ST_MCU_RD_ADDR) ? ST_MCU_RD_END : ST_MCU_WR_END;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // last sample of the read window wins
  always_ff @(posedge CLK2) begin
    if (state == ST_MCU_RD_ADDR) begin
      mcu_din <= mcu_port.rdata;
    end
  end

  assign mcu_port.active = (state == ST_MCU_RD_ADDR) || (state == ST_MCU_WR_ADDR);
  assign mcu_port.write  = (state == ST_MCU_WR_ADDR);
  assign mcu_port.addr   = addr_r;
  assign mcu_port.wdata  = wdata_r;

endmodule

`default_nettype wire

// ==== hw/psram_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module psram_arbiter (
  input  wire logic [15:0] rom_data_in,
  psram_port_if.arbiter    snes_port,
  psram_port_if.arbiter    mcu_port,
  output logic [22:0]      rom_addr,
  output logic [15:0]      rom_data_out,
  output logic             rom_data_drive,
  output logic             rom_we,
  output logic             rom_bhe,
  output logic             rom_ble
);
  import cart_pkg::*;

  logic        sel_mcu;
  psram_addr_t addr;
  byte_t       wdata;
  logic        write;
  logic        lane_lo;
  byte_t       rdata;

  //////////////////////////////////////////////////
  // port select
  //////////////////////////////////////////////////

  // mcu only asks inside free slots, so it takes priority
  assign sel_mcu = mcu_port.active;

  assign addr  = sel_mcu ? mcu_port.addr : snes_port.addr;
  assign wdata = sel_mcu ? mcu_port.wdata : snes_port.wdata;
  // console write only counts on a real hit
  assign write = sel_mcu ? mcu_port.write : (snes_port.active & snes_port.write);

  //////////////////////////////////////////////////
  // psram side
  //////////////////////////////////////////////////

  // odd byte lives in 7:0
  assign lane_lo  = addr[0];
  assign rom_addr = addr[23:1];

  always_comb begin
    if (lane_lo) begin
      rom_data_out = {8'h00, wdata};
    end else begin
      rom_data_out = {wdata, 8'h00};
    end
  end

  // active low strobes
  assign rom_we         = ~write;
  assign rom_data_drive = write;
  // bhe low for the high byte, ble low for the low byte
  assign rom_bhe = lane_lo;
  assign rom_ble = ~lane_lo;

  //////////////////////////////////////////////////
  // read return
  //////////////////////////////////////////////////

  assign rdata = lane_lo ? rom_data_in[7:0] : rom_data_in[15:8];

  // both see the same lane, only the owner uses it
  assign snes_port.rdata = rdata;
  assign mcu_port.rdata  = rdata;

endmodule

`default_nettype wire

// ==== hw/psram_port_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// one requester's view of the shared psram
interface psram_port_if;
  import cart_pkg::*;

  // requester wants the bus this cycle
  logic active;
  // byte address, lane in bit 0
  psram_addr_t addr;
  byte_t wdata;
  // write this cycle
  logic write;
  // byte on the selected lane, from the arbiter
  byte_t rdata;

  modport requester (
    output active,
    output addr,
    output wdata,
    output write,
    input  rdata
  );

  modport arbiter (
    input  active,
    input  addr,
    input  wdata,
    input  write,
    output rdata
  );

endinterface

`default_nettype wire

// ==== hw/snes_bus_sampler.sv ====
`timescale 1ns/100ps
`default_nettype none

module snes_bus_sampler (
  input  wire logic                CLK2,
  input  wire logic                rst,
  input  wire cart_pkg::snes_addr_t snes_addr_in,
  input  wire logic                snes_read_in,
  input  wire logic                snes_write_in,
  input  wire logic                snes_romsel_in,
  input  wire logic                snes_cpu_clk_in,
  input  wire cart_pkg::byte_t     snes_data_in,
  input  wire logic                rom_hit,
  output cart_pkg::snes_addr_t     snes_addr,
  output cart_pkg::byte_t          snes_wdata,
  output logic                     snes_read,
  output logic                     snes_write,
  output logic                     snes_romsel,
  output logic                     rd_start,
  output logic                     wr_end,
  output logic                     free_slot,
  output logic                     snes_dead
);
  import cart_pkg::*;

  // newest sample in bit 0
  logic [SAMPLE_DEPTH-1:0] read_sr;
  logic [SAMPLE_DEPTH-1:0] write_sr;
  logic [SAMPLE_DEPTH-1:0] romsel_sr;
  logic [SAMPLE_DEPTH-1:0] cpu_clk_sr;

  snes_addr_t addr_pipe [ADDR_DELAY];
  byte_t      data_pipe [DATA_DELAY];

  logic cycle_start;
  logic cycle_end;
  logic free_strobe;
  logic [DEAD_CNT_W-1:0] dead_cnt;

  //////////////////////////////////////////////////
  // strobe sampling
  //////////////////////////////////////////////////

  // strobes idle high, cpu clock idles low
  always_ff @(posedge CLK2) begin
    if (rst) begin
      read_sr    <= '1;
      write_sr   <= '1;
      romsel_sr  <= '1;
      cpu_clk_sr <= '0;
      snes_read  <= 1'b1;
      snes_write <= 1'b1;
      snes_romsel <= 1'b1;
    end else begin
      read_sr    <= {read_sr[SAMPLE_DEPTH-2:0], snes_read_in};
      write_sr   <= {write_sr[SAMPLE_DEPTH-2:0], snes_write_in};
      romsel_sr  <= {romsel_sr[SAMPLE_DEPTH-2:0], snes_romsel_in};
      cpu_clk_sr <= {cpu_clk_sr[SAMPLE_DEPTH-2:0], snes_cpu_clk_in};
      // low as soon as either of the two newest samples is low
      snes_read  <= read_sr[1] & read_sr[0];
      snes_write <= write_sr[1] & write_sr[0];
      // romsel taken later, lines up with the address pipe
      snes_romsel <= romsel_sr[4] & romsel_sr[3];
    end
  end

  // edges, pattern needs two agreeing samples
  assign rd_start    = ((read_sr[6:1] | read_sr[7:2]) == 6'b111100);
  assign wr_end      = (write_sr[3:1] == 3'b011);
  assign cycle_start = ((cpu_clk_sr[7:2] & cpu_clk_sr[6:1]) == 6'b000011);
  assign cycle_end   = ((cpu_clk_sr[7:2] | cpu_clk_sr[6:1]) == 6'b111000);

  //////////////////////////////////////////////////
  // address and data delay
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= snes_addr_in;
    for (int i = 1; i < ADDR_DELAY; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
    // extra output stage
    snes_addr <= addr_pipe[ADDR_DELAY-1];
  end

  // write data settles late in the cycle
  always_ff @(posedge CLK2) begin
    data_pipe[0] <= snes_data_in;
    for (int i = 1; i < DATA_DELAY; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  assign snes_wdata = data_pipe[DATA_DELAY-1];

  //////////////////////////////////////////////////
  // free slots and liveness
  //////////////////////////////////////////////////

  // cycle without rom access leaves the psram idle
  always_ff @(posedge CLK2) begin
    if (rst) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  assign free_slot = cycle_end | free_strobe;

  // count clock-low time, stop once dead
  always_ff @(posedge CLK2) begin
    if (rst) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else if (cpu_clk_sr[1]) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (!snes_dead) begin
        dead_cnt <= dead_cnt + 1'b1;
      end
      if (dead_cnt > DEAD_TIMEOUT) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/snes_rom_map.sv ====
`timescale 1ns/100ps
`default_nettype none

module snes_rom_map (
  input  wire logic                  CLK2,
  input  wire logic                  rst,
  input  wire cart_pkg::snes_addr_t  snes_addr,
  input  wire logic                  snes_romsel,
  input  wire logic                  snes_write,
  input  wire cart_pkg::byte_t       snes_wdata,
  input  wire cart_pkg::psram_addr_t rom_mask,
  input  wire cart_pkg::psram_addr_t saveram_mask,
  output logic                       rom_hit,
  psram_port_if.requester            snes_port
);
  import cart_pkg::*;

  byte_t       bank;
  logic        is_saveram;
  psram_addr_t rom_addr;
  psram_addr_t sram_addr;
  logic        write_r;
  psram_addr_t addr_r;
  byte_t       wdata_r;

  //////////////////////////////////////////////////
  // lorom decode
  //////////////////////////////////////////////////

  assign bank = snes_addr[23:16];

  // banks 70-7d, lower half of the bank
  assign is_saveram = (bank >= SAVERAM_BANK_LO) && (bank <= SAVERAM_BANK_HI)
                      && !snes_addr[15];

  // 32k pages packed back to back
  assign rom_addr = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;

  // save ram sits linearly above the rom image
  assign sram_addr = SAVERAM_BASE
                     + ({4'h0, snes_addr[20:16], snes_addr[14:0]} & saveram_mask);

  //////////////////////////////////////////////////
  // registered request
  //////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      rom_hit <= 1'b0;
      write_r <= 1'b0;
    end else begin
      rom_hit <= ~snes_romsel;
      // only save ram is writable
      write_r <= ~snes_write & is_saveram;
    end
  end

  always_ff @(posedge CLK2) begin
    addr_r  <= is_saveram ? sram_addr : rom_addr;
    wdata_r <= snes_wdata;
  end

  assign snes_port.active = rom_hit;
  assign snes_port.addr   = addr_r;
  assign snes_port.wdata  = wdata_r;
  assign snes_port.write  = write_r;

endmodule

`default_nettype wire

// ==== project.f ====
hw/cart_pkg.sv
hw/psram_port_if.sv
hw/snes_bus_sampler.sv
hw/snes_rom_map.sv
hw/mcu_access.sv
hw/psram_arbiter.sv
hw/cart_main.sv
tests/tb_cart_main.sv

// ==== tests/tb_cart_main.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cart_main;
  import cart_pkg::*;

  localparam int CLK_PERIOD = 100;
  // cpu clock half period in CLK2 cycles
  localparam int CPU_HALF = 12;
  // slot wait plus cycle of a normal mcu access
  localparam int RDY_LIMIT = 100;
  localparam longint TOTAL_CYCLES = 2400 + 1600 + 1600 + (longint'(DEAD_TIMEOUT) + 2000) + 2400;
  localparam longint WATCHDOG_NS = 64'd2 * TOTAL_CYCLES * CLK_PERIOD;

  logic        CLK2;
  logic        rst;
  snes_addr_t  snes_addr_in;
  logic        snes_read_in;
  logic        snes_write_in;
  logic        snes_romsel_in;
  logic        snes_cpu_clk_in;
  byte_t       snes_data_in;
  psram_addr_t rom_mask;
  psram_addr_t saveram_mask;
  logic        mcu_rrq;
  logic        mcu_wrq;
  psram_addr_t mcu_addr;
  byte_t       mcu_dout;
  logic [15:0] rom_data_in = 16'h0000;
  byte_t       snes_data_out;
  logic        snes_data_drive;
  logic        snes_databus_oe;
  logic        snes_databus_dir;
  logic [22:0] rom_addr;
  logic [15:0] rom_data_out;
  logic        rom_data_drive;
  logic        rom_we;
  logic        rom_bhe;
  logic        rom_ble;
  byte_t       mcu_din;
  logic        mcu_rdy;

  // sparse psram words and expected bytes
  logic [15:0] psram_mem [int];
  byte_t       ref_mem [int];

  logic [31:0] rng_state = 32'h7cf0_f4e3;
  int          checks = 0;
  int          errors = 0;
  // cpu clock held low in mode 0
  // toggling in mode 1 and held high in mode 2
  int          cpu_mode = 0;

  cart_main UUT (.*);

  initial begin
    CLK2 = 1'b0;
    forever #(CLK_PERIOD / 2) CLK2 = ~CLK2;
  end

  //////////////////////////////////////////////////
  // models
  //////////////////////////////////////////////////

  function automatic logic [15:0] psram_word(input int key);
    if (psram_mem.exists(key)) return psram_mem[key];
    return 16'h0000;
  endfunction

  function automatic byte_t ref_byte(input psram_addr_t a);
    if (ref_mem.exists(int'(a))) return ref_mem[int'(a)];
    return 8'h00;
  endfunction

  // lorom packs the 32k bank halves back to back
  function automatic psram_addr_t lorom_map(input snes_addr_t a);
    return {2'b00, a[22:16], a[14:0]} & rom_mask;
  endfunction

  function automatic psram_addr_t saveram_map(input snes_addr_t a);
    return SAVERAM_BASE + ({4'h0, a[20:16], a[14:0]} & saveram_mask);
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // read data settles half a cycle after the address
  always @(negedge CLK2) begin
    if ($isunknown(rom_addr)) rom_data_in <= 16'h0000;
    else rom_data_in <= psram_word(int'(rom_addr));
  end

  // even byte in 15:8 and odd byte in 7:0
  always @(posedge CLK2) begin : psram_write
    logic [15:0] word;
    int key;
    if (rom_we === 1'b0 && !$isunknown(rom_addr)) begin
      // data bus must be driven for the whole write
      check_value("rom_data_drive", 32'(rom_data_drive), 32'd1);
      key = int'(rom_addr);
      word = psram_word(key);
      if (rom_bhe === 1'b0) word[15:8] = rom_data_out[15:8];
      if (rom_ble === 1'b0) word[7:0] = rom_data_out[7:0];
      psram_mem[key] = word;
    end
  end

  task automatic preload_byte(input psram_addr_t a, input byte_t d);
    logic [15:0] word;
    word = psram_word(int'(a[23:1]));
    if (a[0]) word[7:0] = d;
    else word[15:8] = d;
    psram_mem[int'(a[23:1])] = word;
    ref_mem[int'(a)] = d;
  endtask

  // console cpu clock generator
  initial begin : cpu_clock
    int cnt;
    cnt = 0;
    snes_cpu_clk_in = 1'b0;
    forever begin
      @(posedge CLK2);
      if (cpu_mode == 1) begin
        if (cnt == CPU_HALF - 1) begin
          cnt = 0;
          snes_cpu_clk_in <= ~snes_cpu_clk_in;
        end else begin
          cnt++;
        end
      end else begin
        cnt = 0;
        snes_cpu_clk_in <= (cpu_mode == 2);
      end
    end
  end

  //////////////////////////////////////////////////
  // checks and bus tasks
  //////////////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s (at %0t)", msg, $time);
  endtask

  task automatic wait_rdy_high(input int limit);
    int n;
    n = 0;
    while (mcu_rdy !== 1'b1 && n < limit) begin
      @(negedge CLK2);
      n++;
    end
    if (mcu_rdy !== 1'b1) report_failure("mcu_rdy did not rise after the request");
  endtask

  // one-cycle request pulse and ready drops a cycle later
  task automatic mcu_request(input logic is_write, input psram_addr_t a, input byte_t d);
    @(posedge CLK2);
    mcu_addr <= a;
    mcu_dout <= d;
    if (is_write) mcu_wrq <= 1'b1;
    else mcu_rrq <= 1'b1;
    @(posedge CLK2);
    mcu_wrq <= 1'b0;
    mcu_rrq <= 1'b0;
    @(negedge CLK2);
    check_value("mcu_rdy", 32'(mcu_rdy), 32'd0);
  endtask

  task automatic mcu_write(input psram_addr_t a, input byte_t d);
    mcu_request(1'b1, a, d);
    wait_rdy_high(RDY_LIMIT);
    ref_mem[int'(a)] = d;
  endtask

  task automatic mcu_read_check(input psram_addr_t a);
    mcu_request(1'b0, a, 8'h00);
    wait_rdy_high(RDY_LIMIT);
    check_value("mcu_din", 32'(mcu_din), 32'(ref_byte(a)));
  endtask

  // sample late in the cpu high phase clear of mcu slots
  task automatic console_rom_read(input snes_addr_t a);
    logic prev;
    int n;
    @(posedge CLK2);
    snes_addr_in   <= a;
    snes_romsel_in <= 1'b0;
    snes_read_in   <= 1'b0;
    repeat (14) @(posedge CLK2);
    @(negedge CLK2);
    prev = snes_cpu_clk_in;
    n = 0;
    while (!(snes_cpu_clk_in && !prev) && n < 4 * CPU_HALF) begin
      prev = snes_cpu_clk_in;
      @(negedge CLK2);
      n++;
    end
    if (n >= 4 * CPU_HALF) report_failure("console cpu clock stopped during a read");
    repeat (8) @(negedge CLK2);
    check_value("snes_data_out", 32'(snes_data_out), 32'(ref_byte(lorom_map(a))));
    check_value("snes_databus_oe", 32'(snes_databus_oe), 32'd0);
    check_value("snes_databus_dir", 32'(snes_databus_dir), 32'd1);
    check_value("snes_data_drive", 32'(snes_data_drive), 32'd1);
    check_value("rom_data_drive", 32'(rom_data_drive), 32'd0);
  endtask

  // address first and write strobe after the address pipe
  task automatic console_save_write(input snes_addr_t a, input byte_t d);
    @(posedge CLK2);
    snes_addr_in   <= a;
    snes_data_in   <= d;
    snes_romsel_in <= 1'b0;
    snes_write_in  <= 1'b1;
    repeat (10) @(posedge CLK2);
    snes_write_in <= 1'b0;
    repeat (8) @(posedge CLK2);
    snes_write_in <= 1'b1;
    repeat (10) @(posedge CLK2);
    snes_romsel_in <= 1'b1;
    ref_mem[int'(saveram_map(a))] = d;
  endtask

  function automatic snes_addr_t random_lorom();
    logic [31:0] r;
    r = next_rand();
    // upper half of banks 00-3f and 80-bf
    return {r[23], 1'b0, r[21:16], 1'b1, r[14:0]};
  endfunction

  function automatic snes_addr_t random_saveram();
    logic [31:0] r;
    r = next_rand();
    return {SAVERAM_BANK_LO + {4'h0, r[19:16] % 4'd14}, 1'b0, r[14:0]};
  endfunction

  task automatic end_test(input string name, input int err_before);
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  //////////////////////////////////////////////////
  // watchdog and test sequence
  //////////////////////////////////////////////////

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    psram_addr_t t1_addrs [$];
    snes_addr_t  rom_list [$];
    snes_addr_t  sram_list [$];
    logic [31:0] r;
    int e0;
    rst = 1'b1;
    snes_addr_in = '0;
    snes_read_in = 1'b1;
    snes_write_in = 1'b1;
    snes_romsel_in = 1'b1;
    snes_data_in = 8'h00;
    rom_mask = 24'h3F_FFFF;
    saveram_mask = 24'h0F_FFFF;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_dout = 8'h00;

    // outputs settle to their idle levels while reset is held
    e0 = errors;
    repeat (3) @(posedge CLK2);
    @(negedge CLK2);
    check_value("mcu_rdy", 32'(mcu_rdy), 32'd1);
    check_value("rom_we", 32'(rom_we), 32'd1);
    check_value("rom_data_drive", 32'(rom_data_drive), 32'd0);
    check_value("snes_databus_oe", 32'(snes_databus_oe), 32'd1);
    check_value("snes_databus_dir", 32'(snes_databus_dir), 32'd0);
    check_value("snes_data_drive", 32'(snes_data_drive), 32'd0);
    @(posedge CLK2);
    rst <= 1'b0;
    end_test("reset", e0);
    repeat (4) @(posedge CLK2);

    // mcu traffic with the console dead
    e0 = errors;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      t1_addrs.push_back(r[23:0]);
      mcu_write(r[23:0], r[31:24]);
    end
    foreach (t1_addrs[i]) mcu_read_check(t1_addrs[i]);
    end_test("mcu_dead", e0);

    // console rom reads
    e0 = errors;
    cpu_mode = 1;
    for (int i = 0; i < 24; i++) begin
      rom_list.push_back(random_lorom());
      r = next_rand();
      preload_byte(lorom_map(rom_list[i]), r[7:0]);
    end
    foreach (rom_list[i]) console_rom_read(rom_list[i]);
    @(posedge CLK2);
    snes_romsel_in <= 1'b1;
    snes_read_in <= 1'b1;
    end_test("rom_read", e0);

    // save ram writes from the console read back by the mcu
    e0 = errors;
    for (int i = 0; i < 16; i++) begin
      sram_list.push_back(random_saveram());
      r = next_rand();
      console_save_write(sram_list[i], r[7:0]);
    end
    foreach (sram_list[i]) mcu_read_check(saveram_map(sram_list[i]));
    end_test("saveram", e0);

    // without cpu cycles the mcu waits until the console dies
    e0 = errors;
    cpu_mode = 2;
    repeat (20) @(posedge CLK2);
    mcu_request(1'b0, saveram_map(sram_list[0]), 8'h00);
    repeat (500) @(negedge CLK2);
    check_value("mcu_rdy", 32'(mcu_rdy), 32'd0);
    cpu_mode = 0;
    wait_rdy_high(int'(DEAD_TIMEOUT) + 100);
    check_value("mcu_din", 32'(mcu_din), 32'(ref_byte(saveram_map(sram_list[0]))));
    cpu_mode = 1;
    repeat (40) @(posedge CLK2);
    end_test("liveness", e0);

    // mcu writes during console rom reads
    e0 = errors;
    fork
      begin
        for (int i = 0; i < 20; i++) console_rom_read(rom_list[i]);
      end
      begin
        psram_addr_t a;
        for (int i = 0; i < 20; i++) begin
          r = next_rand();
          // above the rom image and below save ram
          a = {2'b01, r[21:0]};
          mcu_write(a, r[29:22]);
          mcu_read_check(a);
        end
      end
    join
    @(posedge CLK2);
    snes_romsel_in <= 1'b1;
    snes_read_in <= 1'b1;
    end_test("interleave", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
